/* hw/control_encoder.sv */
`timescale 1ns/10ps

module control_encoder (
    input  ctrl_pkg::state_t       i_state,
    input  isa_pkg::instr_class_t  i_class,
    input  isa_pkg::instr_fields_t i_fields,
    input  isa_pkg::mem_status_t   i_status,
    input  logic                   i_trap,
    output ctrl_pkg::ctrl_t        o_ctrl,
    output ctrl_pkg::csr_ctrl_t    o_csr
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    csr_addr_t s_csr_addr; // CSR slot from bits 22:21.

    assign s_csr_addr = csr_addr_t'(i_fields.instr_22_20[2:1]);

    always_comb begin
        o_ctrl            = '0;
        o_ctrl.alu_op     = ALU_ADD;
        o_ctrl.result_src = RES_ALU_OUT;
        o_ctrl.alu_src_a  = SRC_A_PC;
        o_ctrl.alu_src_b  = SRC_B_REG;

        o_csr              = '0;
        o_csr.write_addr_1 = s_csr_addr;
        o_csr.write_addr_2 = s_csr_addr;
        o_csr.read_addr    = s_csr_addr;

        case (i_state)
            FETCH: begin
                // PC + 4 while the I-cache is started.
                o_ctrl.result_src     = RES_ALU_RESULT;
                o_ctrl.alu_src_a      = SRC_A_PC;
                o_ctrl.alu_src_b      = SRC_B_FOUR;
                o_ctrl.start_i_cache  = 1'b1;
                o_ctrl.fetch_state    = 1'b1;
                o_ctrl.pc_update      = ~i_status.stall_instr;
                o_ctrl.instr_write_en = ~i_status.stall_instr;
            end

            DECODE: begin
                o_ctrl.alu_src_a = SRC_A_OLD_PC; // Branch/AUIPC target.
                o_ctrl.alu_src_b = SRC_B_IMM;
            end

            MEMADDR: begin
                o_ctrl.alu_src_a       = SRC_A_REG;
                o_ctrl.alu_src_b       = SRC_B_IMM;
                o_ctrl.result_src      = RES_ALU_RESULT;
                o_ctrl.reg_mem_addr_we = 1'b1;
            end

            MEMREAD: begin
                o_ctrl.alu_src_a     = SRC_A_REG;
                o_ctrl.alu_src_b     = SRC_B_IMM;
                o_ctrl.start_d_cache = 1'b1;
                o_ctrl.mem_reg_we    = ~i_status.stall_data;
            end

            MEMWRITE: begin
                o_ctrl.alu_src_a     = SRC_A_REG;
                o_ctrl.alu_src_b     = SRC_B_IMM;
                o_ctrl.start_d_cache = 1'b1;
                o_ctrl.mem_write_en  = ~i_status.stall_data;
                o_ctrl.mem_reg_we    = ~i_status.stall_data;
            end

            MEMWB: begin
                o_ctrl.result_src   = RES_MEM_DATA;
                o_ctrl.reg_write_en = 1'b1;
            end

            EXECUTER: begin
                o_ctrl.alu_src_a = SRC_A_REG;
                o_ctrl.alu_src_b = SRC_B_REG;
                o_ctrl.alu_op    = (i_class == CLS_ALU_RW) ? ALU_FUNC_W : ALU_FUNC;
            end

            EXECUTEI: begin
                o_ctrl.alu_src_a = SRC_A_REG;
                o_ctrl.alu_src_b = SRC_B_IMM;
                o_ctrl.alu_op    = (i_class == CLS_ALU_IW) ? ALU_FUNC_W : ALU_FUNC;
            end

            ALUWB: o_ctrl.reg_write_en = 1'b1;

            JAL: begin
                // Jump target already in the ALU register; link = old PC + 4.
                o_ctrl.alu_src_a = SRC_A_OLD_PC;
                o_ctrl.alu_src_b = SRC_B_FOUR;
                o_ctrl.pc_update = 1'b1;
            end

            BRANCH: begin
                o_ctrl.alu_src_a = SRC_A_REG;
                o_ctrl.alu_src_b = SRC_B_REG;
                o_ctrl.alu_op    = ALU_BRANCH;
                o_ctrl.branch    = 1'b1;
            end

            LOADI: begin
                o_ctrl.result_src   = RES_IMM;
                o_ctrl.reg_write_en = 1'b1;
            end

            TRAP: begin
                o_csr.read_addr   = CSR_MTVEC;
                o_ctrl.result_src = RES_TRAP_VEC;
                o_ctrl.pc_update  = 1'b1;
            end

            CSR_EXECUTE: begin
                o_ctrl.alu_src_a  = i_fields.func_3[2] ? SRC_A_ZIMM : SRC_A_REG;
                o_ctrl.alu_src_b  = SRC_B_CSR;
                o_ctrl.alu_op     = ALU_CSR;
                o_ctrl.result_src = RES_ALU_RESULT;
                o_csr.csr_we_2    = 1'b1;
                o_csr.csr_reg_we  = 1'b1; // Keep old CSR value for rd.
            end

            CSR_WB: begin
                o_ctrl.result_src   = RES_CSR_READ_REG;
                o_ctrl.reg_write_en = 1'b1;
            end

            default: o_ctrl.fetch_state = 1'b0;
        endcase

        // Cause into mcause, faulting PC into mepc.
        if (i_trap) begin
            o_csr.csr_we_1       = 1'b1;
            o_csr.write_addr_1   = CSR_MCAUSE;
            o_csr.csr_we_2       = 1'b1;
            o_csr.write_addr_2   = CSR_MEPC;
            o_ctrl.result_src    = RES_OLD_PC;
            o_ctrl.start_d_cache = 1'b0;
            o_ctrl.reg_write_en  = 1'b0; // No commit from a faulting op.
            o_ctrl.mem_write_en  = 1'b0;
        end
    end

endmodule

/* hw/ctrl_pkg.sv */
package ctrl_pkg;

    // ------------------------------
    // FSM states
    // ------------------------------
    typedef enum logic [3:0] {
        FETCH       = 4'd0,
        DECODE      = 4'd1,
        MEMADDR     = 4'd2,
        MEMREAD     = 4'd3,
        MEMWB       = 4'd4,
        MEMWRITE    = 4'd5,
        EXECUTER    = 4'd6,
        ALUWB       = 4'd7,
        EXECUTEI    = 4'd8,
        JAL         = 4'd9,
        BRANCH      = 4'd10,
        LOADI       = 4'd11,
        TRAP        = 4'd12,
        CSR_EXECUTE = 4'd14,
        CSR_WB      = 4'd15
    } state_t;

    // ------------------------------
    // Datapath selects
    // ------------------------------

    // Result mux feeding the register file and PC.
    typedef enum logic [2:0] {
        RES_ALU_OUT      = 3'd0, // Registered ALU output.
        RES_MEM_DATA     = 3'd1,
        RES_ALU_RESULT   = 3'd2, // ALU output of this cycle.
        RES_IMM          = 3'd3,
        RES_CSR_DATA     = 3'd4,
        RES_CSR_READ_REG = 3'd5,
        RES_OLD_PC       = 3'd6,
        RES_TRAP_VEC     = 3'd7
    } result_src_t;

    typedef enum logic [1:0] {
        SRC_A_PC     = 2'd0,
        SRC_A_OLD_PC = 2'd1,
        SRC_A_REG    = 2'd2,
        SRC_A_ZIMM   = 2'd3  // CSR immediate forms.
    } alu_src_a_t;

    typedef enum logic [1:0] {
        SRC_B_REG  = 2'd0,
        SRC_B_IMM  = 2'd1,
        SRC_B_FOUR = 2'd2,
        SRC_B_CSR  = 2'd3
    } alu_src_b_t;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_BRANCH = 3'd1,
        ALU_FUNC   = 3'd2, // Operation from func3/func7.
        ALU_FUNC_W = 3'd3, // Same, 32-bit word form.
        ALU_CSR    = 3'd4
    } alu_op_t;

    typedef enum logic [1:0] {
        CSR_MEPC   = 2'd0,
        CSR_MCAUSE = 2'd1,
        CSR_MTVEC  = 2'd2
    } csr_addr_t;

    // ------------------------------
    // Control bundles
    // ------------------------------
    typedef struct packed {
        alu_op_t     alu_op;
        result_src_t result_src;
        alu_src_a_t  alu_src_a;
        alu_src_b_t  alu_src_b;
        logic        reg_write_en;
        logic        pc_update;
        logic        mem_write_en;
        logic        instr_write_en;
        logic        start_i_cache;
        logic        start_d_cache;
        logic        branch;
        logic        mem_reg_we;
        logic        fetch_state;
        logic        reg_mem_addr_we;
    } ctrl_t;

    typedef struct packed {
        logic      csr_we_1;
        logic      csr_we_2;
        logic      csr_reg_we;
        csr_addr_t write_addr_1;
        csr_addr_t write_addr_2;
        csr_addr_t read_addr;
    } csr_ctrl_t;

endpackage

/* hw/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder (
    input  isa_pkg::instr_fields_t i_fields,
    output isa_pkg::instr_class_t  o_class,
    output logic                   o_is_csr,
    output logic                   o_is_ebreak
);
    import isa_pkg::*;

    logic s_func_3_nz;
    logic s_sys_priv; // MRET, WFI and friends.

    assign s_func_3_nz = |i_fields.func_3;
    assign s_sys_priv  = |i_fields.instr_22_20[2:1];

    // CSR ops carry a nonzero func3; ECALL/EBREAK differ in bit 20.
    assign o_is_csr    = (i_fields.op == OPC_SYSTEM) & s_func_3_nz;
    assign o_is_ebreak = i_fields.instr_22_20[0];

    always_comb begin
        case (i_fields.op)
            OPC_LOAD:      o_class = CLS_LOAD;
            OPC_OP_IMM:    o_class = CLS_ALU_I;
            OPC_JALR:      o_class = CLS_JALR;
            OPC_OP_IMM_32: o_class = CLS_ALU_IW;
            OPC_STORE:     o_class = CLS_STORE;
            OPC_OP:        o_class = CLS_ALU_R;
            OPC_OP_32:     o_class = CLS_ALU_RW;
            OPC_BRANCH:    o_class = CLS_BRANCH;
            OPC_JAL:       o_class = CLS_JAL;
            OPC_AUIPC:     o_class = CLS_AUIPC;
            OPC_LUI:       o_class = CLS_LUI;
            OPC_SYSTEM: begin
                // Only CSR ops, ECALL and EBREAK are supported.
                if (!s_func_3_nz && s_sys_priv) o_class = CLS_ILLEGAL;
                else                            o_class = CLS_SYSTEM;
            end
            default:       o_class = CLS_ILLEGAL;
        endcase
    end

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

    // ------------------------------
    // Instruction encoding
    // ------------------------------

    // Major opcodes, instruction bits 6:0.
    typedef enum logic [6:0] {
        OPC_LOAD      = 7'b0000011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_JALR      = 7'b1100111,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_STORE     = 7'b0100011,
        OPC_OP        = 7'b0110011,
        OPC_OP_32     = 7'b0111011,
        OPC_BRANCH    = 7'b1100011,
        OPC_JAL       = 7'b1101111,
        OPC_AUIPC     = 7'b0010111,
        OPC_LUI       = 7'b0110111,
        OPC_SYSTEM    = 7'b1110011
    } opcode_t;

    // Decoded instruction class. Code 11 is free.
    typedef enum logic [3:0] {
        CLS_LOAD    = 4'd0,
        CLS_ALU_I   = 4'd1,
        CLS_JALR    = 4'd2,
        CLS_ALU_IW  = 4'd3,
        CLS_STORE   = 4'd4,
        CLS_ALU_R   = 4'd5,
        CLS_ALU_RW  = 4'd6,
        CLS_BRANCH  = 4'd7,
        CLS_JAL     = 4'd8,
        CLS_AUIPC   = 4'd9,
        CLS_LUI     = 4'd10,
        CLS_SYSTEM  = 4'd12,
        CLS_ILLEGAL = 4'd13
    } instr_class_t;

    // Instruction fields seen by the controller.
    typedef struct packed {
        logic [6:0] op;
        logic [2:0] func_3;
        logic       func_7_0;    // Bit 25.
        logic [2:0] instr_22_20; // CSR slot, ECALL/EBREAK select.
    } instr_fields_t;

    // ------------------------------
    // Memory side status
    // ------------------------------
    typedef struct packed {
        logic stall_instr;
        logic stall_data;
        logic instr_addr_ma;
        logic load_addr_ma;
        logic store_addr_ma;
        logic illegal_load;
        logic illegal_alu;
    } mem_status_t;

    // Exception causes written to mcause.
    typedef enum logic [3:0] {
        MC_INSTR_MISALIGN = 4'd0,
        MC_ILLEGAL        = 4'd2,
        MC_BREAKPOINT     = 4'd3,
        MC_LOAD_MISALIGN  = 4'd4,
        MC_STORE_MISALIGN = 4'd6,
        MC_ECALL          = 4'd11
    } mcause_t;

endpackage

/* hw/main_fsm.sv */
`timescale 1ns/10ps

module main_fsm (
    input  logic                   clk,
    input  logic                   arstn,
    input  isa_pkg::instr_fields_t i_fields,
    input  isa_pkg::mem_status_t   i_status,
    output ctrl_pkg::ctrl_t        o_ctrl,
    output ctrl_pkg::csr_ctrl_t    o_csr,
    output isa_pkg::mcause_t       o_mcause
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    instr_class_t s_class;
    logic         s_is_csr;
    logic         s_is_ebreak;
    logic         s_trap;
    state_t       s_state;

    instr_decoder decoder_i (
        .i_fields    (i_fields),
        .o_class     (s_class),
        .o_is_csr    (s_is_csr),
        .o_is_ebreak (s_is_ebreak)
    );

    trap_detect trap_i (
        .i_state     (s_state),
        .i_class     (s_class),
        .i_is_csr    (s_is_csr),
        .i_is_ebreak (s_is_ebreak),
        .i_fields    (i_fields),
        .i_status    (i_status),
        .o_trap      (s_trap),
        .o_mcause    (o_mcause)
    );

    state_sequencer seq_i (
        .clk      (clk),
        .arstn    (arstn),
        .i_class  (s_class),
        .i_is_csr (s_is_csr),
        .i_status (i_status),
        .i_trap   (s_trap),
        .o_state  (s_state)
    );

    control_encoder enc_i (
        .i_state  (s_state),
        .i_class  (s_class),
        .i_fields (i_fields),
        .i_status (i_status),
        .i_trap   (s_trap),
        .o_ctrl   (o_ctrl),
        .o_csr    (o_csr)
    );

endmodule

/* hw/state_sequencer.sv */
`timescale 1ns/10ps

module state_sequencer (
    input  logic                  clk,
    input  logic                  arstn,
    input  isa_pkg::instr_class_t i_class,
    input  logic                  i_is_csr,
    input  isa_pkg::mem_status_t  i_status,
    input  logic                  i_trap,
    output ctrl_pkg::state_t      o_state
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    state_t s_next;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            o_state <= FETCH;
        end else begin
            o_state <= s_next;
        end
    end

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        s_next = o_state;

        case (o_state)
            FETCH: begin
                if (i_status.stall_instr) s_next = FETCH; // Wait for I-cache.
                else                      s_next = DECODE;
            end

            DECODE: begin
                case (i_class)
                    CLS_LOAD:   s_next = MEMADDR;
                    CLS_STORE:  s_next = MEMADDR;
                    CLS_JALR:   s_next = MEMADDR; // Target computed there.
                    CLS_ALU_I:  s_next = EXECUTEI;
                    CLS_ALU_IW: s_next = EXECUTEI;
                    CLS_ALU_R:  s_next = EXECUTER;
                    CLS_ALU_RW: s_next = EXECUTER;
                    CLS_BRANCH: s_next = BRANCH;
                    CLS_JAL:    s_next = JAL;
                    CLS_AUIPC:  s_next = ALUWB;   // Sum formed in DECODE.
                    CLS_LUI:    s_next = LOADI;
                    CLS_SYSTEM: s_next = i_is_csr ? CSR_EXECUTE : TRAP;
                    default:    s_next = TRAP;
                endcase
            end

            MEMADDR: begin
                case (i_class)
                    CLS_LOAD:  s_next = MEMREAD;
                    CLS_STORE: s_next = MEMWRITE;
                    CLS_JALR:  s_next = JAL;
                    default:   s_next = FETCH;
                endcase
            end

            MEMREAD: begin
                if (i_status.stall_data) s_next = MEMREAD;
                else                     s_next = MEMWB;
            end

            MEMWRITE: begin
                if (i_status.stall_data) s_next = MEMWRITE;
                else                     s_next = FETCH;
            end

            EXECUTER:    s_next = ALUWB;
            EXECUTEI:    s_next = ALUWB;
            JAL:         s_next = ALUWB; // Link write.
            CSR_EXECUTE: s_next = CSR_WB;
            MEMWB:       s_next = FETCH;
            ALUWB:       s_next = FETCH;
            BRANCH:      s_next = FETCH;
            LOADI:       s_next = FETCH;
            TRAP:        s_next = FETCH;
            CSR_WB:      s_next = FETCH;
            default:     s_next = FETCH;
        endcase

        // A trap in any state takes the one-cycle TRAP detour.
        if (i_trap) s_next = TRAP;
    end

endmodule

/* hw/trap_detect.sv */
`timescale 1ns/10ps

module trap_detect (
    input  ctrl_pkg::state_t       i_state,
    input  isa_pkg::instr_class_t  i_class,
    input  logic                   i_is_csr,
    input  logic                   i_is_ebreak,
    input  isa_pkg::instr_fields_t i_fields,
    input  isa_pkg::mem_status_t   i_status,
    output logic                   o_trap,
    output isa_pkg::mcause_t       o_mcause
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic s_bad_func_7; // M extension bit on OP or OP_32.

    assign s_bad_func_7 = i_fields.func_7_0 &
                          ((i_fields.op == OPC_OP) | (i_fields.op == OPC_OP_32));

    always_comb begin
        o_trap   = 1'b0;
        o_mcause = MC_INSTR_MISALIGN;

        case (i_state)
            FETCH: o_trap = i_status.instr_addr_ma;

            DECODE: begin
                if (i_class == CLS_ILLEGAL) begin
                    o_trap   = 1'b1;
                    o_mcause = MC_ILLEGAL;
                end else if (i_class == CLS_SYSTEM && !i_is_csr) begin
                    o_trap   = 1'b1;
                    o_mcause = i_is_ebreak ? MC_BREAKPOINT : MC_ECALL;
                end
            end

            MEMREAD: begin
                o_trap = i_status.illegal_load | i_status.load_addr_ma;
                // Illegal load wins over misalignment.
                o_mcause = i_status.illegal_load ? MC_ILLEGAL : MC_LOAD_MISALIGN;
            end

            MEMWRITE: begin
                o_trap   = i_status.store_addr_ma;
                o_mcause = MC_STORE_MISALIGN;
            end

            ALUWB: begin
                o_trap   = i_status.illegal_alu | s_bad_func_7;
                o_mcause = MC_ILLEGAL;
            end

            CSR_EXECUTE: begin
                o_trap   = i_status.illegal_alu;
                o_mcause = MC_ILLEGAL;
            end

            default: o_trap = 1'b0;
        endcase
    end

endmodule

/* main_fsm.f */
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/instr_decoder.sv
hw/trap_detect.sv
hw/state_sequencer.sv
hw/control_encoder.sv
hw/main_fsm.sv
test/clk_gen.sv
test/main_fsm_properties.sv
test/main_fsm_tb.sv

/* run.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f main_fsm.f --top-module main_fsm_tb -o main_fsm_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/main_fsm_sim +verilator+error+limit+100 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
echo "Pass message not found in the output"
exit 1

/* test/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen (
    output logic o_clk,
    output logic o_arstn
);

    // 8 ns period.
    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    // Reset held over 16 rising edges, released just after the last one.
    initial begin
        o_arstn = 1'b0;
        repeat (16) @(posedge o_clk);
        #1 o_arstn = 1'b1;
    end

endmodule

/* test/main_fsm_properties.sv */
`timescale 1ns/10ps

module main_fsm_properties (
    input logic                   clk,
    input logic                   arstn,
    input isa_pkg::instr_fields_t i_fields,
    input isa_pkg::mem_status_t   i_status,
    input ctrl_pkg::ctrl_t        i_ctrl,
    input ctrl_pkg::csr_ctrl_t    i_csr,
    input isa_pkg::mcause_t       i_mcause
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    int fail_count = 0;

    logic fetch_ok;  // FETCH that moves on to DECODE.
    logic is_alu;
    logic is_lui;
    logic is_csr_op;
    logic is_branch;
    logic alu_clean; // No trap expected in ALUWB.

    assign fetch_ok  = arstn & i_ctrl.fetch_state & ~i_status.stall_instr &
                       ~i_status.instr_addr_ma;
    assign is_alu    = (i_fields.op == OPC_OP) | (i_fields.op == OPC_OP_32) |
                       (i_fields.op == OPC_OP_IMM) | (i_fields.op == OPC_OP_IMM_32);
    assign is_lui    = (i_fields.op == OPC_LUI);
    assign is_csr_op = (i_fields.op == OPC_SYSTEM) & (i_fields.func_3 != 3'd0);
    assign is_branch = (i_fields.op == OPC_BRANCH);
    assign alu_clean = ~i_status.illegal_alu & ~(i_fields.func_7_0 &
                       ((i_fields.op == OPC_OP) | (i_fields.op == OPC_OP_32)));

    // ------------------------------
    // Cause table
    // ------------------------------
    function automatic mcause_t expected_cause(logic in_fetch, instr_fields_t f,
                                               mem_status_t s);
        mcause_t cause;
        cause = MC_ILLEGAL; // ALU, jump and CSR faults.
        if (in_fetch) begin
            cause = MC_INSTR_MISALIGN;
        end else if (f.op == OPC_LOAD) begin
            cause = s.illegal_load ? MC_ILLEGAL : MC_LOAD_MISALIGN;
        end else if (f.op == OPC_STORE) begin
            cause = MC_STORE_MISALIGN;
        end else if (f.op == OPC_SYSTEM && f.func_3 == 3'd0 && f.instr_22_20[2:1] == 2'd0) begin
            cause = f.instr_22_20[0] ? MC_BREAKPOINT : MC_ECALL;
        end
        return cause;
    endfunction

    task automatic record_failure(string what);
        fail_count++;
        $error("[ERROR] %0t: %s", $time, what);
    endtask

    // ------------------------------
    // Fetch and writeback timing
    // ------------------------------
    a_reset_state: assert property (@(posedge clk) disable iff (!arstn)
        !$past(arstn) |-> i_ctrl.fetch_state && i_ctrl.start_i_cache &&
        !i_ctrl.reg_write_en && !i_ctrl.mem_write_en && !i_ctrl.branch &&
        !i_csr.csr_we_1 && !i_csr.csr_we_2 && !i_csr.csr_reg_we)
        else record_failure("Controls not at their FETCH values after reset");

    a_fetch_hold: assert property (@(posedge clk) disable iff (!arstn)
        i_ctrl.fetch_state && i_status.stall_instr && !i_status.instr_addr_ma
        |-> !i_ctrl.pc_update && !i_ctrl.instr_write_en)
        else record_failure("PC or IR written while the I-cache stalls");

    a_fetch_stay: assert property (@(posedge clk) disable iff (!arstn)
        i_ctrl.fetch_state && i_status.stall_instr && !i_status.instr_addr_ma
        |=> i_ctrl.fetch_state)
        else record_failure("FETCH left during an I-cache stall");

    a_alu_wb: assert property (@(posedge clk) disable iff (!arstn)
        $past(fetch_ok, 3) && $past(is_alu, 2) && alu_clean
        |-> i_ctrl.reg_write_en && i_ctrl.result_src == RES_ALU_OUT)
        else record_failure("ALU writeback missing 3 cycles after fetch");

    a_lui_wb: assert property (@(posedge clk) disable iff (!arstn)
        $past(fetch_ok, 2) && $past(is_lui, 1)
        |-> i_ctrl.reg_write_en && i_ctrl.result_src == RES_IMM)
        else record_failure("LUI writeback missing 2 cycles after fetch");

    a_load_wb: assert property (@(posedge clk) disable iff (!arstn)
        i_ctrl.mem_reg_we && i_ctrl.start_d_cache && !i_ctrl.mem_write_en
        |=> i_ctrl.reg_write_en && i_ctrl.result_src == RES_MEM_DATA)
        else record_failure("Load writeback missing after MEMREAD");

    a_store_stall: assert property (@(posedge clk) disable iff (!arstn)
        i_ctrl.mem_write_en |-> !i_status.stall_data)
        else record_failure("Memory write while the D-cache stalls");

    a_store_no_wb: assert property (@(posedge clk) disable iff (!arstn)
        i_fields.op == OPC_STORE |-> !i_ctrl.reg_write_en)
        else record_failure("Register write during a store");

    // ------------------------------
    // Traps
    // ------------------------------
    a_trap_write: assert property (@(posedge clk) disable iff (!arstn)
        i_csr.csr_we_1 |-> i_csr.csr_we_2 && i_ctrl.result_src == RES_OLD_PC &&
        i_csr.write_addr_1 == CSR_MCAUSE && i_csr.write_addr_2 == CSR_MEPC &&
        i_mcause == expected_cause(i_ctrl.fetch_state, i_fields, i_status))
        else record_failure("Wrong trap CSR write or cause");

    a_trap_vec: assert property (@(posedge clk) disable iff (!arstn)
        i_csr.csr_we_1 |=> i_ctrl.pc_update && i_ctrl.result_src == RES_TRAP_VEC)
        else record_failure("No jump to the trap vector after a trap");

    a_trap_ret: assert property (@(posedge clk) disable iff (!arstn)
        $past(i_csr.csr_we_1, 2) |-> i_ctrl.fetch_state)
        else record_failure("No FETCH two cycles after a trap");

    // ------------------------------
    // CSR and branch
    // ------------------------------
    a_csr_exec: assert property (@(posedge clk) disable iff (!arstn)
        $past(fetch_ok, 2) && $past(is_csr_op, 1)
        |-> i_csr.csr_we_2 && i_csr.csr_reg_we &&
            !$past(i_csr.csr_we_2) && !$past(i_csr.csr_reg_we))
        else record_failure("CSR write enables not raised together");

    a_csr_wb: assert property (@(posedge clk) disable iff (!arstn)
        $past(fetch_ok, 3) && $past(is_csr_op, 2) && !$past(i_status.illegal_alu)
        |-> i_ctrl.reg_write_en && i_ctrl.result_src == RES_CSR_READ_REG)
        else record_failure("CSR writeback missing 3 cycles after fetch");

    a_branch: assert property (@(posedge clk) disable iff (!arstn)
        $past(fetch_ok, 2) && $past(is_branch, 1)
        |-> i_ctrl.branch && i_ctrl.alu_op == ALU_BRANCH)
        else record_failure("Branch compare missing 2 cycles after fetch");

    a_branch_ret: assert property (@(posedge clk) disable iff (!arstn)
        $past(fetch_ok, 3) && $past(is_branch, 2) |-> i_ctrl.fetch_state)
        else record_failure("No FETCH after a branch");

endmodule

bind main_fsm main_fsm_properties props_i (
    .clk      (clk),
    .arstn    (arstn),
    .i_fields (i_fields),
    .i_status (i_status),
    .i_ctrl   (o_ctrl),
    .i_csr    (o_csr),
    .i_mcause (o_mcause)
);

/* test/main_fsm_tb.sv */
`timescale 1ns/10ps

module main_fsm_tb;
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int INSTR_COUNT = 300;
    localparam int WAIT_LIMIT  = 200; // Cycles allowed per wait loop.

    logic          clk;
    logic          arstn;
    instr_fields_t fields;
    mem_status_t   status;
    ctrl_t         ctrl;
    csr_ctrl_t     csr;
    mcause_t       mcause;
    int            seed;

    clk_gen clk_gen_i (
        .o_clk   (clk),
        .o_arstn (arstn)
    );

    main_fsm dut_i (
        .clk      (clk),
        .arstn    (arstn),
        .i_fields (fields),
        .i_status (status),
        .o_ctrl   (ctrl),
        .o_csr    (csr),
        .o_mcause (mcause)
    );

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Run aborted");
    endtask

    // ------------------------------
    // Random stimulus
    // ------------------------------
    function automatic int rand_below(int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic logic [6:0] pick_opcode();
        logic [6:0]  op;
        logic [31:0] r;
        r = $random(seed);
        case (rand_below(13))
            0:       op = OPC_LOAD;
            1:       op = OPC_OP_IMM;
            2:       op = OPC_JALR;
            3:       op = OPC_OP_IMM_32;
            4:       op = OPC_STORE;
            5:       op = OPC_OP;
            6:       op = OPC_OP_32;
            7:       op = OPC_BRANCH;
            8:       op = OPC_JAL;
            9:       op = OPC_AUIPC;
            10:      op = OPC_LUI;
            11:      op = OPC_SYSTEM;
            default: op = r[6:0]; // Seldom a legal opcode.
        endcase
        return op;
    endfunction

    task automatic pick_fields();
        logic [31:0] r;
        r = $random(seed);
        fields.op          = pick_opcode();
        fields.func_3      = r[2:0];
        fields.func_7_0    = (r[6:4] == 3'd0); // Rare M-extension bit.
        fields.instr_22_20 = r[9:7];
        if (fields.op == OPC_SYSTEM) begin
            if (r[12]) fields.func_3 = 3'd0;                     // ECALL/EBREAK family.
            if (r[11:10] != 2'd0) fields.instr_22_20[2:1] = 2'd0;
        end
    endtask

    // Stalls fairly often, error flags rarely.
    task automatic draw_status();
        status.stall_instr   = (rand_below(3) == 0);
        status.stall_data    = (rand_below(3) == 0);
        status.instr_addr_ma = (rand_below(24) == 0);
        status.load_addr_ma  = (rand_below(12) == 0);
        status.store_addr_ma = (rand_below(12) == 0);
        status.illegal_load  = (rand_below(16) == 0);
        status.illegal_alu   = (rand_below(20) == 0);
    endtask

    // Step until FETCH is back after the instruction has left it.
    task automatic run_to_fetch();
        int   cycles;
        logic left_fetch;
        cycles     = 0;
        left_fetch = 1'b0;
        do begin
            @(posedge clk);
            #1;
            draw_status();
            cycles++;
            if (!ctrl.fetch_state) left_fetch = 1'b1;
        end while (!(left_fetch && ctrl.fetch_state) && cycles < WAIT_LIMIT);
        if (!(left_fetch && ctrl.fetch_state)) abort_run("Timeout waiting for return to FETCH");
    endtask

    // Stop at the first assertion failure.
    always @(negedge clk) begin
        if (dut_i.props_i.fail_count != 0) abort_run("An assertion on main_fsm failed");
    end

    initial begin
        int n;
        int cycles;
        seed               = 26;
        fields             = '0;
        status             = '0;
        status.stall_instr = 1'b1; // Park in FETCH until stimulus starts.

        cycles = 0;
        while (!arstn && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!arstn) abort_run("Timeout waiting for reset release");
        #1;

        for (n = 0; n < INSTR_COUNT; n++) begin
            pick_fields();
            draw_status();
            run_to_fetch();
        end

        if (dut_i.props_i.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run("Assertion failures were reported");
        end
    end

endmodule
